// File: Makefile
TB_TOP := uart_cmd_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f uart_cmd_top.f --top-module $(TB_TOP)

run: build
	./obj_dir/V$(TB_TOP)

lint:
	verilator --lint-only -Wall --timing -f uart_cmd_top.f --top-module uart_cmd_top

clean:
	rm -rf obj_dir

// File: cdc_sync.sv
`default_nettype none

module cdc_sync (
    input  logic sourceClk,
    input  logic rst,
    input  logic async_in,
    output logic sync_out,
    output logic rising,
    output logic falling
);

    // Stages 0 and 1 synchronize, stage 2 is the previous value
    logic [2:0] sync_q;

    always_ff @(posedge sourceClk) begin
        if (rst) begin
            // Serial line idles high, so no false edge after reset
            sync_q <= 3'b111;
        end else begin
            sync_q <= {sync_q[1:0], async_in};
        end
    end

    assign sync_out = sync_q[1];

    // One-cycle edge pulses
    assign rising  = sync_q[1] & ~sync_q[2];
    assign falling = ~sync_q[1] & sync_q[2];

endmodule

`default_nettype wire

// File: cmd_decode.sv
`default_nettype none

module cmd_decode (
    input  logic                  sourceClk,
    input  logic                  rst,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_complete,
    input  logic                  cmd_ready,
    output logic                  cmd_valid,
    output uart_cmd_pkg::opcode_t cmd_op,
    output logic [7:0]            cmd_a,
    output logic [7:0]            cmd_b
);

    import uart_cmd_pkg::*;

    dec_state_t state;

    // Command is offered for as long as it sits in the pending slot
    assign cmd_valid = (state == DEC_PENDING);

    // ----------------------------------------
    // Byte position
    // ----------------------------------------
    always_ff @(posedge sourceClk) begin
        if (rst) begin
            state <= DEC_OPCODE;
        end else begin
            unique case (state)
                DEC_OPCODE: begin
                    if (rx_complete) begin
                        state <= DEC_OPERAND_A;
                    end
                end
                DEC_OPERAND_A: begin
                    if (rx_complete) begin
                        state <= DEC_OPERAND_B;
                    end
                end
                DEC_OPERAND_B: begin
                    // Third byte completes the command
                    if (rx_complete) begin
                        state <= DEC_PENDING;
                    end
                end
                DEC_PENDING: begin
                    // Held until execute takes it, new bytes are dropped
                    if (cmd_ready) begin
                        state <= DEC_OPCODE;
                    end
                end
                default: begin
                    state <= DEC_OPCODE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Command fields
    // ----------------------------------------
    // Raw opcode is kept, even when it is not a listed one
    always_ff @(posedge sourceClk) begin
        if (rx_complete) begin
            unique case (state)
                DEC_OPCODE:    cmd_op <= opcode_t'(rx_byte);
                DEC_OPERAND_A: cmd_a  <= rx_byte;
                DEC_OPERAND_B: cmd_b  <= rx_byte;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cmd_execute.sv
`default_nettype none

module cmd_execute (
    input  logic                  sourceClk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  uart_cmd_pkg::opcode_t cmd_op,
    input  logic [7:0]            cmd_a,
    input  logic [7:0]            cmd_b,
    output logic                  cmd_ready,
    input  logic                  res_ready,
    output logic                  res_valid,
    output logic [7:0]            res_status,
    output logic [7:0]            res_data
);

    import uart_cmd_pkg::*;

    localparam logic [7:0] STATUS_OK     = 8'h00;
    localparam logic [7:0] STATUS_BAD_OP = 8'h01;

    logic cmd_fire;

    // Single output register, free whenever no result is held
    assign cmd_ready = ~res_valid;
    assign cmd_fire  = cmd_valid & cmd_ready;

    always_ff @(posedge sourceClk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (cmd_fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            // Result handed to the reply side
            res_valid <= 1'b0;
        end
    end

    // ALU, sums wrap at 8 bits
    always_ff @(posedge sourceClk) begin
        if (cmd_fire) begin
            res_status <= STATUS_OK;
            unique case (cmd_op)
                OP_ADD: res_data <= cmd_a + cmd_b;
                OP_SUB: res_data <= cmd_a - cmd_b;
                OP_AND: res_data <= cmd_a & cmd_b;
                OP_XOR: res_data <= cmd_a ^ cmd_b;
                default: begin
                    // Unknown opcode
                    res_status <= STATUS_BAD_OP;
                    res_data   <= 8'h00;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: result_send.sv
`default_nettype none

module result_send (
    input  logic       sourceClk,
    input  logic       rst,
    input  logic       res_valid,
    input  logic [7:0] res_status,
    input  logic [7:0] res_data,
    output logic       res_ready,
    input  logic       tx_ready,
    output logic       tx_valid,
    output logic [7:0] tx_byte
);

    // 0 sends the status byte, 1 sends the result byte
    logic byte_sel;

    // A held result always has a byte to offer
    assign tx_valid = res_valid;
    assign tx_byte  = byte_sel ? res_data : res_status;

    // Release the result with its second byte
    assign res_ready = byte_sel & tx_ready;

    always_ff @(posedge sourceClk) begin
        if (rst) begin
            byte_sel <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            // Alternate status and result on each byte accepted
            byte_sel <= ~byte_sel;
        end
    end

endmodule

`default_nettype wire

// File: uart_cmd_cfg.svh
`ifndef UART_CMD_CFG_SVH
`define UART_CMD_CFG_SVH

// System clock in Hz
`define SOURCE_FREQ 1000000

// Line rate in bits per second
// Gives 16 clocks per bit at the clock above
`define BAUD 62500

// Phase accumulator width, the carry bit sits just above it
`define ACCUMULATOR_WIDTH 16

// Receiver stop check
// 1 waits a quarter bit of idle line (one stop bit)
// 0 waits a full bit period instead (TWO_STOP_BITS)
`define ONE_STOP_BIT 1

// Accumulator step per clock, rounded to nearest
`define BAUD_INC (((`BAUD << (`ACCUMULATOR_WIDTH - 4)) + (`SOURCE_FREQ >> 5)) / (`SOURCE_FREQ >> 4))

`endif

// File: uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

    // ----------------------------------------
    // Serial line state machines
    // ----------------------------------------

    // Receiver, one state per part of the frame
    typedef enum logic [2:0] {
        RX_RESET,
        RX_IDLE,
        RX_START_BIT,
        RX_HALF_BIT,
        RX_RECEIVING,
        RX_STOP_BIT,
        RX_COMPLETE
    } rx_state_t;

    // Transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // ----------------------------------------
    // Command layer
    // ----------------------------------------

    // First byte of a command, other values are rejected by execute
    typedef enum logic [7:0] {
        OP_ADD = 8'h01,
        OP_SUB = 8'h02,
        OP_AND = 8'h03,
        OP_XOR = 8'h04
    } opcode_t;

    // Position of the next byte in the command
    typedef enum logic [1:0] {
        DEC_OPCODE,
        DEC_OPERAND_A,
        DEC_OPERAND_B,
        DEC_PENDING
    } dec_state_t;

endpackage

`default_nettype wire

// File: uart_cmd_props.sv
`default_nettype none

module uart_cmd_props (
    input logic                  sourceClk,
    input logic                  rst,
    input logic                  rx_complete,
    input logic                  cmd_valid,
    input logic                  cmd_ready,
    input uart_cmd_pkg::opcode_t cmd_op,
    input logic [7:0]            cmd_a,
    input logic [7:0]            cmd_b,
    input logic                  res_valid,
    input logic                  res_ready,
    input logic [7:0]            res_status,
    input logic [7:0]            res_data,
    input logic                  tx_ready,
    input logic                  tx
);

    // ----------------------------------------
    // Handshake stability
    // ----------------------------------------
    // Decoder keeps the command until execute takes it
    cmd_hold: assert property (@(posedge sourceClk) disable iff (rst)
        cmd_valid && !cmd_ready |=>
            cmd_valid && $stable(cmd_op) && $stable(cmd_a) && $stable(cmd_b))
        else $error("cmd handshake dropped valid or changed data while stalled");

    // Result register held across both reply bytes
    res_hold: assert property (@(posedge sourceClk) disable iff (rst)
        res_valid && !res_ready |=>
            res_valid && $stable(res_status) && $stable(res_data))
        else $error("res handshake dropped valid or changed data while stalled");

    // ----------------------------------------
    // Serial side
    // ----------------------------------------
    // One strobe per received byte
    rx_strobe: assert property (@(posedge sourceClk) disable iff (rst)
        rx_complete |=> !rx_complete)
        else $error("rx_complete high on two cycles in a row");

    // Transmitter idle means a high line
    tx_idle: assert property (@(posedge sourceClk) disable iff (rst)
        tx_ready |-> tx)
        else $error("tx low while the transmitter is idle");

endmodule

bind uart_cmd_top uart_cmd_props u_props (
    .sourceClk   (sourceClk),
    .rst         (rst),
    .rx_complete (rx_complete),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_op      (cmd_op),
    .cmd_a       (cmd_a),
    .cmd_b       (cmd_b),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_status  (res_status),
    .res_data    (res_data),
    .tx_ready    (tx_ready),
    .tx          (tx)
);

`default_nettype wire

// File: uart_cmd_tb.sv
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_cmd_tb;

    import uart_cmd_pkg::*;

    localparam int HALF_PERIOD   = 20;
    // Clocks per serial bit, from the line settings
    localparam int CLKS_PER_BIT  = `SOURCE_FREQ / `BAUD;
    // Longest quiet gap between two reply bytes
    localparam int REPLY_TIMEOUT = 40 * CLKS_PER_BIT;
    localparam int RANDOM_CMDS   = 20;
    localparam int BURST_CMDS    = 5;

    logic sourceClk;
    logic rst;
    logic rx;
    logic tx;

    // Bytes seen on tx, and the bytes they should be
    logic [7:0]  reply_q[$];
    logic [7:0]  expect_q[$];
    logic [31:0] lcg_state;

    uart_cmd_top uut (
        .sourceClk (sourceClk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx)
    );

    initial begin
        sourceClk = 1'b0;
        forever #HALF_PERIOD sourceClk = ~sourceClk;
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic fail_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        $display("Fail %s expected 0x%02h actual 0x%02h", name, expected, actual);
        stop_run("reply byte does not match the command");
    endtask

    // ----------------------------------------
    // Reference model and random source
    // ----------------------------------------
    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // Upper bits are the better mixed ones
        return lcg_state[23:16];
    endfunction

    // Listed opcodes are accepted, anything else is rejected
    function automatic logic [7:0] expected_status(input logic [7:0] op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: return 8'h00;
            default: return 8'h01;
        endcase
    endfunction

    function automatic logic [7:0] expected_result(input logic [7:0] op,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
        case (op)
            OP_ADD: return 8'(a + b);
            OP_SUB: return 8'(a - b);
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            default: return 8'h00;
        endcase
    endfunction

    // ----------------------------------------
    // Host side of the serial link
    // ----------------------------------------
    // One bit cell, held for a full bit period
    task automatic drive_bit(input logic value);
        @(posedge sourceClk);
        rx <= value;
        repeat (CLKS_PER_BIT - 1) @(posedge sourceClk);
    endtask

    // 8N1 frame, LSB first, no gap to the next frame
    task automatic send_byte(input logic [7:0] value);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(value[i]);
        end
        drive_bit(1'b1);
    endtask

    task automatic send_command(input logic [7:0] op, input logic [7:0] a,
                                input logic [7:0] b);
        expect_q.push_back(expected_status(op));
        expect_q.push_back(expected_result(op, a, b));
        send_byte(op);
        send_byte(a);
        send_byte(b);
    endtask

    // Compare the replies of count commands, status first
    task automatic check_replies(input int count);
        int         i;
        int         waited;
        logic [7:0] got;
        logic [7:0] want;
        string      name;
        for (i = 0; i < 2 * count; i++) begin
            waited = 0;
            while (reply_q.size() == 0) begin
                @(negedge sourceClk);
                waited++;
                if (waited > REPLY_TIMEOUT) begin
                    stop_run("timed out waiting for a reply byte on tx");
                end
            end
            got  = reply_q.pop_front();
            want = expect_q.pop_front();
            name = (i % 2 == 0) ? "tx status byte" : "tx result byte";
            assert (got == want) else fail_value(name, want, got);
        end
    endtask

    // ----------------------------------------
    // Reply monitor
    // ----------------------------------------
    // Samples on the falling clock edge, away from DUT updates
    initial begin : tx_monitor
        logic       prev;
        logic [7:0] data;
        int         i;
        prev = 1'b1;
        forever begin
            @(negedge sourceClk);
            if (prev === 1'b1 && tx === 1'b0) begin
                // Middle of the start bit
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge sourceClk);
                assert (tx === 1'b0) else stop_run("start bit on tx ended too early");
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge sourceClk);
                    data[i] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge sourceClk);
                assert (tx === 1'b1) else stop_run("stop bit on tx was low");
                reply_q.push_back(data);
            end
            prev = tx;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int         i;
        int         n;
        int         sel;
        logic [7:0] op;
        rst           = 1'b1;
        rx            = 1'b1;
        lcg_state     = 32'd15;
        repeat (4) @(posedge sourceClk);
        rst <= 1'b0;

        // Quiet line with no command
        for (n = 0; n < 20 * CLKS_PER_BIT; n++) begin
            @(negedge sourceClk);
            assert (tx === 1'b1) else stop_run("tx left idle with no command sent");
            assert (reply_q.size() == 0) else stop_run("reply byte with no command sent");
        end

        // Sum wraps past 0xFF
        send_command(OP_ADD, 8'hF0, 8'h20);
        check_replies(1);

        // Random operands, first three force each opcode once
        for (i = 0; i < RANDOM_CMDS; i++) begin
            sel = (i < 3) ? i : int'(lcg_byte() % 8'd3);
            case (sel)
                0:       op = OP_SUB;
                1:       op = OP_AND;
                default: op = OP_XOR;
            endcase
            send_command(op, lcg_byte(), lcg_byte());
            check_replies(1);
        end

        // Unlisted opcode
        send_command(8'h7F, lcg_byte(), lcg_byte());
        check_replies(1);

        // Burst with no idle between frames, replies overlap the sends
        for (i = 0; i < BURST_CMDS; i++) begin
            case (i % 4)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                2:       op = OP_AND;
                default: op = OP_XOR;
            endcase
            send_command(op, lcg_byte(), lcg_byte());
        end
        check_replies(BURST_CMDS);

        // Nothing extra may follow
        repeat (20 * CLKS_PER_BIT) @(negedge sourceClk);
        if (reply_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run("extra reply byte on tx after the last command");
        end
    end

endmodule

`default_nettype wire

// File: uart_cmd_top.f
+incdir+.
uart_cmd_pkg.sv
cdc_sync.sv
uart_rx.sv
uart_tx.sv
cmd_decode.sv
cmd_execute.sv
result_send.sv
uart_cmd_top.sv
uart_cmd_props.sv
uart_cmd_tb.sv

// File: uart_cmd_top.sv
`default_nettype none

module uart_cmd_top (
    input  logic sourceClk,
    input  logic rst,
    input  logic rx,
    output logic tx
);

    import uart_cmd_pkg::*;

    // Received bytes
    logic [7:0] rx_byte;
    logic       rx_complete;

    // Decoded command
    logic       cmd_valid;
    logic       cmd_ready;
    opcode_t    cmd_op;
    logic [7:0] cmd_a;
    logic [7:0] cmd_b;

    // Execute result
    logic       res_valid;
    logic       res_ready;
    logic [7:0] res_status;
    logic [7:0] res_data;

    // Reply bytes to the line
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] tx_byte;

    // ----------------------------------------
    // Command path
    // ----------------------------------------
    uart_rx u_rx (
        .sourceClk   (sourceClk),
        .rst         (rst),
        .rx          (rx),
        .rx_byte     (rx_byte),
        .rx_complete (rx_complete)
    );

    cmd_decode u_dec (
        .sourceClk   (sourceClk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_complete (rx_complete),
        .cmd_ready   (cmd_ready),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_a       (cmd_a),
        .cmd_b       (cmd_b)
    );

    cmd_execute u_exe (
        .sourceClk   (sourceClk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_a       (cmd_a),
        .cmd_b       (cmd_b),
        .cmd_ready   (cmd_ready),
        .res_ready   (res_ready),
        .res_valid   (res_valid),
        .res_status  (res_status),
        .res_data    (res_data)
    );

    // ----------------------------------------
    // Reply path
    // ----------------------------------------
    result_send u_res (
        .sourceClk   (sourceClk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res_status  (res_status),
        .res_data    (res_data),
        .res_ready   (res_ready),
        .tx_ready    (tx_ready),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte)
    );

    uart_tx u_tx (
        .sourceClk   (sourceClk),
        .rst         (rst),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_ready    (tx_ready),
        .tx          (tx)
    );

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_rx (
    input  logic       sourceClk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_complete
);

    import uart_cmd_pkg::*;

    localparam logic [`ACCUMULATOR_WIDTH:0] COUNT_INC = (`ACCUMULATOR_WIDTH + 1)'(`BAUD_INC);
    localparam bit ONE_STOP = (`ONE_STOP_BIT != 0);

    rx_state_t state;

    // ----------------------------------------
    // Synchronized line
    // ----------------------------------------
    logic rx_sync;
    logic rx_rising;
    logic rx_falling;

    cdc_sync u_sync (
        .sourceClk (sourceClk),
        .rst       (rst),
        .async_in  (rx),
        .sync_out  (rx_sync),
        .rising    (rx_rising),
        .falling   (rx_falling)
    );

    // ----------------------------------------
    // Baud timing
    // ----------------------------------------
    // Extra top bit catches the rollover
    logic [`ACCUMULATOR_WIDTH:0] baud_counter;
    logic baud_tick;
    logic baud_half_tick;
    logic baud_quarter_tick;
    logic stop_seen;

    assign baud_tick         = baud_counter[`ACCUMULATOR_WIDTH];
    assign baud_half_tick    = baud_counter[`ACCUMULATOR_WIDTH-1];
    assign baud_quarter_tick = baud_counter[`ACCUMULATOR_WIDTH-2];

    // Quarter bit into the stop bit, or the full bit for two stop bits
    assign stop_seen = ONE_STOP ? baud_quarter_tick : baud_tick;

    // Bits still to sample, and the shift register, LSB arrives first
    logic [2:0] bit_cnt;
    logic [7:0] rx_bits;

    always_ff @(posedge sourceClk) begin
        if (rst) begin
            state        <= RX_RESET;
            rx_complete  <= 1'b0;
            baud_counter <= '0;
        end else begin
            baud_counter <= baud_counter + COUNT_INC;
            // Strobe defaults low
            rx_complete  <= 1'b0;

            unique case (state)
                RX_RESET: begin
                    baud_counter <= '0;
                    bit_cnt      <= '0;
                    state        <= RX_IDLE;
                end
                RX_IDLE: begin
                    // Start bit edge restarts the bit timing
                    // One step in, the tick is acted on a cycle after the carry
                    if (rx_falling) begin
                        baud_counter <= COUNT_INC;
                        state        <= RX_START_BIT;
                    end
                end
                RX_START_BIT: begin
                    // Line back high before mid start bit, treat as noise
                    if (rx_rising) begin
                        state <= RX_IDLE;
                    end else if (baud_half_tick) begin
                        baud_counter <= COUNT_INC;
                        state        <= RX_HALF_BIT;
                    end
                end
                RX_HALF_BIT: begin
                    // One bit on from mid start is the center of bit 0
                    if (baud_tick) begin
                        baud_counter <= COUNT_INC;
                        rx_bits      <= {rx_sync, rx_bits[7:1]};
                        bit_cnt      <= 3'd7;
                        state        <= RX_RECEIVING;
                    end
                end
                RX_RECEIVING: begin
                    if (baud_tick) begin
                        baud_counter <= COUNT_INC;
                        if (bit_cnt == 3'd0) begin
                            // Now at the center of the stop bit
                            state <= RX_STOP_BIT;
                        end else begin
                            rx_bits <= {rx_sync, rx_bits[7:1]};
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end
                RX_STOP_BIT: begin
                    // Wait for an idle line before handing the byte on
                    if (stop_seen && rx_sync) begin
                        baud_counter <= COUNT_INC;
                        rx_byte      <= rx_bits;
                        rx_complete  <= 1'b1;
                        state        <= RX_COMPLETE;
                    end
                end
                RX_COMPLETE: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_RESET;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_tx (
    input  logic       sourceClk,
    input  logic       rst,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_ready,
    output logic       tx
);

    import uart_cmd_pkg::*;

    localparam logic [`ACCUMULATOR_WIDTH:0] COUNT_INC = (`ACCUMULATOR_WIDTH + 1)'(`BAUD_INC);

    tx_state_t state;

    // ----------------------------------------
    // Baud timing
    // ----------------------------------------
    logic [`ACCUMULATOR_WIDTH:0] baud_counter;
    logic baud_tick;

    assign baud_tick = baud_counter[`ACCUMULATOR_WIDTH];

    // Bits left after the current one, and the outgoing byte
    logic [2:0] bit_cnt;
    logic [7:0] shift_q;

    // Accept a new byte only between frames
    assign tx_ready = (state == TX_IDLE);

    always_ff @(posedge sourceClk) begin
        if (rst) begin
            state        <= TX_IDLE;
            tx           <= 1'b1;
            baud_counter <= '0;
        end else begin
            // Drop the carry and keep the phase remainder
            baud_counter <= {1'b0, baud_counter[`ACCUMULATOR_WIDTH-1:0]} + COUNT_INC;

            unique case (state)
                TX_IDLE: begin
                    if (tx_valid) begin
                        shift_q      <= tx_byte;
                        tx           <= 1'b0;
                        // One step in, so the start bit is a full period
                        baud_counter <= COUNT_INC;
                        state        <= TX_START;
                    end
                end
                TX_START: begin
                    if (baud_tick) begin
                        tx      <= shift_q[0];
                        shift_q <= {1'b0, shift_q[7:1]};
                        bit_cnt <= 3'd7;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (baud_tick) begin
                        if (bit_cnt == 3'd0) begin
                            // Stop bit
                            tx    <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            tx      <= shift_q[0];
                            shift_q <= {1'b0, shift_q[7:1]};
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    // Full stop bit before the next start
                    if (baud_tick) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
